// ==== rvDecodeExec_input.txt ====
# P pc word = program word; W rd value = writeback; R target = redirect
# Expected records are matched in order, wrong-path words have none
P 00 00500093 W 1 00000005
P 04 FFD00113 W 2 fffffffd
P 08 002081B3 W 3 00000002
P 0c 40118233 W 4 fffffffd
P 10 00309293 W 5 00000028
P 14 00415313 W 6 0fffffff
P 18 40115393 W 7 fffffffe
P 1c 00109433 W 8 000000a0
P 20 001154B3 W 9 07ffffff
P 24 40115533 W 10 ffffffff
P 28 001125B3 W 11 00000001
P 2c 00113633 W 12 00000000
P 30 FFF0C693 W 13 fffffffa
P 34 0300E713 W 14 00000035
P 38 0F017793 W 15 000000f0
P 3c 00708013 W 0 00000000
P 40 00100833 W 16 00000005
P 44 123458B7 W 17 12345000
P 48 00001917 W 18 00001048
P 4c FFE12993 W 19 00000001
P 50 0040BA13 W 20 00000000
P 54 01008663 R 00000060 W 0 00000000
P 58 00100A93
P 5c 00200B13
P 60 01009463 W 0 00000000
P 64 00114463 R 0000006c W 0 00000000
P 68 00100A93
P 6c 00116463 W 0 00000000
P 70 0020D463 R 00000078 W 0 00000000
P 74 00200B13
P 78 0020F463 W 0 00000000
P 7c 00C00BEF R 00000088 W 23 00000080
P 80 00100A93
P 84 00200B13
P 88 09800C13 W 24 00000098
P 8c 004C0CE7 R 0000009c W 25 00000090
P 90 00100A93
P 94 00200B13
P 98 00100A93
P 9c 017C8D33 W 26 00000110
P a0 FF0D0D93 W 27 00000100
P a4 0B500067 R 000000b4 W 0 00000000
P a8 00100A93
P ac 00200B13
P b0 00100A93
P b4 7FF00E13 W 28 000007ff
E

// ==== rvDecodeExec.f ====
rvCorePkg.sv
ctrlDecoder.sv
instDecodeStage.sv
regFile.sv
execStage.sv
resultStage.sv
rvDecodeExec.sv
rvDecodeExec_sva.sv
rvDecodeExec_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build with Verilator, run, and look for the pass line in the log
rm -f sim.log
verilator --binary --timing -Wno-fatal --top-module rvDecodeExec_tb \
	-f rvDecodeExec.f --Mdir obj_dir -o simv > build.log 2>&1 &&
./obj_dir/simv > sim.log 2>&1
grep -qx "Simulation finished: PASS" sim.log && echo "Run passed" ||
	{ echo "Run failed, see build.log and sim.log"; exit 1; }

// ==== rvDecodeExec_tb.sv ====
`default_nettype none

module rvDecodeExec_tb;

	logic clk;
	logic nrst;
	logic [31:0] pc;
	logic [31:0] instr;
	logic instrValid;
	logic hold;
	logic wbValid;
	logic [4:0] wbRd;
	logic [31:0] wbData;
	logic redirect;
	logic [31:0] redirectPc;

	logic [31:0] progMem [0:63]; // Indexed by pc/4
	logic loaded [0:63];
	byte expKind [0:63]; // "W" writeback or "R" redirect
	logic [4:0] expRd [0:63];
	logic [31:0] expVal [0:63];
	int expCount;
	int expIdx; // Next record to match
	int idle; // Cycles since last event
	int valueErrors;
	int otherErrors;
	logic [31:0] fetchPc;
	logic checking; // Trace matching on

	rvDecodeExec #(.XLEN(32)) UUT (
		.clk        (clk),
		.nrst       (nrst),
		.pc         (pc),
		.instr      (instr),
		.instrValid (instrValid),
		.hold       (hold),
		.wbValid    (wbValid),
		.wbRd       (wbRd),
		.wbData     (wbData),
		.redirect   (redirect),
		.redirectPc (redirectPc)
	);

	always #50 clk = ~clk;

	// Program words and expected trace, one token stream
	task automatic loadStimulus();
		int fd;
		int code;
		int rd;
		logic [31:0] addr;
		logic [31:0] word;
		string tok;
		string rest;
		fd = $fopen("rvDecodeExec_input.txt", "r");
		if (fd == 0)
		begin
			$display("Cannot open rvDecodeExec_input.txt");
			otherErrors++;
			return;
		end
		while (!$feof(fd))
		begin
			code = $fscanf(fd, "%s", tok);
			if (code != 1)
				break;
			if (tok == "#")
				code = $fgets(rest, fd); // Comment line
			else if (tok == "P")
			begin
				code = $fscanf(fd, "%h %h", addr, word);
				progMem[addr[7:2]] = word;
				loaded[addr[7:2]] = 1'b1;
			end
			else if (tok == "W")
			begin
				code = $fscanf(fd, "%d %h", rd, word);
				expKind[expCount] = "W";
				expRd[expCount] = rd[4:0];
				expVal[expCount] = word;
				expCount++;
			end
			else if (tok == "R")
			begin
				code = $fscanf(fd, "%h", word);
				expKind[expCount] = "R";
				expRd[expCount] = '0;
				expVal[expCount] = word;
				expCount++;
			end
			else if (tok == "E")
				break;
		end
		$fclose(fd);
	endtask

	// One event against the next expected record
	task automatic matchEvent(input byte kind, input logic [4:0] rd, input logic [31:0] val);
		if (expIdx >= expCount)
		begin
			$display("Unexpected %s event at time %0t after the trace ended",
				(kind == "W") ? "writeback" : "redirect", $time);
			otherErrors++;
		end
		else
		begin
			if (expKind[expIdx] != kind)
			begin
				$display("Event %0d at time %0t is a %s, a %s was expected", expIdx, $time,
					(kind == "W") ? "writeback" : "redirect",
					(expKind[expIdx] == "W") ? "writeback" : "redirect");
				otherErrors++;
			end
			else if (kind == "W")
			begin
				if (rd !== expRd[expIdx])
				begin
					$display("[ERROR] t=%0t wbRd expected %0d actual %0d", $time, expRd[expIdx], rd);
					valueErrors++;
				end
				if (val !== expVal[expIdx])
				begin
					$display("[ERROR] t=%0t wbData expected %h actual %h", $time,
						expVal[expIdx], val);
					valueErrors++;
				end
			end
			else if (val !== expVal[expIdx])
			begin
				$display("[ERROR] t=%0t redirectPc expected %h actual %h", $time,
					expVal[expIdx], val);
				valueErrors++;
			end
			expIdx++;
		end
	endtask

	// Fetcher, restarts at the target once redirect is seen
	always @(negedge clk)
	begin
		if (!nrst)
		begin
			fetchPc = '0;
			pc = '0;
			instr = '0;
			instrValid = 1'b0;
			hold = 1'b0;
		end
		else if (redirect)
		begin
			fetchPc = redirectPc;
			instrValid = 1'b0; // Squashed this edge anyway
			hold = 1'b0;
		end
		else
		begin
			hold = ($urandom % 5) == 0;
			pc = fetchPc;
			if ((fetchPc[31:2] < 64) && loaded[fetchPc[7:2]])
			begin
				instr = progMem[fetchPc[7:2]];
				instrValid = 1'b1;
			end
			else
			begin
				instr = '0;
				instrValid = 1'b0; // Past the program
			end
			if (!hold)
				fetchPc = fetchPc + 32'd4;
		end
	end

	// Writeback of the older instruction before a redirect of the same cycle
	always @(negedge clk)
	begin
		if (checking && !nrst)
		begin
			if (wbValid || redirect)
			begin
				$display("wbValid or redirect high during reset at time %0t", $time);
				otherErrors++;
			end
		end
		else if (checking)
		begin
			if (wbValid)
			begin
				matchEvent("W", wbRd, wbData);
				idle = 0;
			end
			if (redirect)
			begin
				matchEvent("R", 5'd0, redirectPc);
				idle = 0;
			end
		end
	end

	initial
	begin
		clk = 1'b0;
		nrst = 1'b0;
		pc = '0;
		instr = '0;
		instrValid = 1'b0;
		hold = 1'b0;
		expCount = 0;
		expIdx = 0;
		idle = 0;
		valueErrors = 0;
		otherErrors = 0;
		checking = 1'b1;
		void'($urandom(13835));
		for (int i = 0; i < 64; i++)
		begin
			progMem[i] = '0;
			loaded[i] = 1'b0;
		end
		loadStimulus();
		repeat (3) @(negedge clk);
		nrst = 1'b1;
		while ((expIdx < expCount) && (idle < 50))
		begin
			@(posedge clk);
			idle++;
		end
		if (expIdx < expCount)
		begin
			$display("Timeout waiting for event %0d of %0d", expIdx, expCount);
			otherErrors++;
		end
		repeat (10) @(negedge clk); // Wrong-path results must not show
		// Refill from pc 0 so the final reset meets live state
		@(posedge clk);
		checking = 1'b0;
		fetchPc = '0;
		idle = 0;
		@(negedge clk);
		while (!wbValid && (idle < 50))
		begin
			@(negedge clk);
			idle++;
		end
		if (!wbValid)
		begin
			$display("Timeout waiting for a retirement before the final reset");
			otherErrors++;
		end
		nrst = 1'b0; // Asynchronous, clears mid-flight
		#10;
		if (wbValid || redirect)
		begin
			$display("Outputs not cleared by the final reset");
			otherErrors++;
		end
		$display("Errors: %0d value mismatches, %0d other failures", valueErrors, otherErrors);
		if ((valueErrors == 0) && (otherErrors == 0))
			$display("Simulation finished: PASS");
		else
			$display("Simulation finished: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

// ==== rvDecodeExec_sva.sv ====
`default_nettype none

module rvDecodeExecChecks (
	input logic clk,
	input logic nrst,
	input logic wbValid,
	input logic [4:0] wbRd,
	input logic [31:0] wbData,
	input logic redirect
);

	// Redirect is a one-cycle pulse
	redirectPulse: assert property (@(posedge clk) disable iff (!nrst) redirect |=> !redirect)
		else $error("redirect high on two consecutive cycles");

	resetQuiet: assert property (@(posedge clk) !nrst |-> !wbValid)
		else $error("wbValid high while in reset");

	// Branches and x0 writes carry no data
	zeroRdData: assert property (@(posedge clk) disable iff (!nrst)
		(wbValid && (wbRd == 5'd0)) |-> (wbData == 32'd0))
		else $error("wbRd zero with nonzero wbData");

endmodule

bind rvDecodeExec rvDecodeExecChecks sva (
	.clk     (clk),
	.nrst    (nrst),
	.wbValid (wbValid),
	.wbRd    (wbRd),
	.wbData  (wbData),
	.redirect(redirect)
);

`default_nettype wire

// ==== rvDecodeExec.sv ====
`default_nettype none

module rvDecodeExec #(
	parameter int XLEN = rvCorePkg::XLEN
) (
	input logic clk,
	input logic nrst,
	input logic [XLEN-1:0] pc,
	input logic [31:0] instr,
	input logic instrValid,
	input logic hold, // Only back-pressure
	output logic wbValid,
	output logic [rvCorePkg::RegIdxW-1:0] wbRd,
	output logic [XLEN-1:0] wbData,
	output logic redirect,
	output logic [XLEN-1:0] redirectPc
);
	import rvCorePkg::*;

	decodedT decoded;
	execResT result;
	logic [RegIdxW-1:0] rs1;
	logic [RegIdxW-1:0] rs2;
	logic [XLEN-1:0] rs1Data;
	logic [XLEN-1:0] rs2Data;
	logic wrEn;
	logic [RegIdxW-1:0] wrAddr;
	logic [XLEN-1:0] wrData;

	instDecodeStage decodeStage (
		.clk        (clk),
		.nrst       (nrst),
		.pc         (pc),
		.instr      (instr),
		.instrValid (instrValid),
		.hold       (hold),
		.squash     (redirect), // Drops the two younger slots
		.rs1        (rs1),
		.rs2        (rs2),
		.decoded    (decoded)
	);

	regFile regs (
		.clk     (clk),
		.nrst    (nrst),
		.rs1     (rs1),
		.rs2     (rs2),
		.rs1Data (rs1Data),
		.rs2Data (rs2Data),
		.wrEn    (wrEn),
		.wrAddr  (wrAddr),
		.wrData  (wrData)
	);

	execStage #(.XLEN(XLEN)) exStage (
		.clk        (clk),
		.nrst       (nrst),
		.decoded    (decoded),
		.rs1Data    (rs1Data),
		.rs2Data    (rs2Data),
		.result     (result),
		.redirect   (redirect),
		.redirectPc (redirectPc)
	);

	resultStage #(.XLEN(XLEN)) resStage (
		.clk     (clk),
		.nrst    (nrst),
		.result  (result),
		.wrEn    (wrEn),
		.wrAddr  (wrAddr),
		.wrData  (wrData),
		.wbValid (wbValid),
		.wbRd    (wbRd),
		.wbData  (wbData)
	);

endmodule

`default_nettype wire

// ==== resultStage.sv ====
`default_nettype none

module resultStage #(
	parameter int XLEN = rvCorePkg::XLEN
) (
	input logic clk,
	input logic nrst,
	input rvCorePkg::execResT result,
	output logic wrEn,
	output logic [rvCorePkg::RegIdxW-1:0] wrAddr,
	output logic [XLEN-1:0] wrData,
	output logic wbValid,
	output logic [rvCorePkg::RegIdxW-1:0] wbRd,
	output logic [XLEN-1:0] wbData
);
	import rvCorePkg::*;

	execResT resReg; // Retiring instruction

	always_ff @(posedge clk or negedge nrst)
	begin
		if (!nrst)
			resReg <= '0;
		else
			resReg <= result;
	end

	// Register file write port
	assign wrEn = resReg.valid && resReg.regWrite;
	assign wrAddr = resReg.rd;
	assign wrData = resReg.data;

	// Every retirement shows, branches with rd and data zero
	assign wbValid = resReg.valid;
	assign wbRd = wrEn ? resReg.rd : '0;
	assign wbData = wrEn ? resReg.data : '0;

endmodule

`default_nettype wire

// ==== execStage.sv ====
`default_nettype none

module execStage #(
	parameter int XLEN = rvCorePkg::XLEN
) (
	input logic clk,
	input logic nrst,
	input rvCorePkg::decodedT decoded,
	input logic [XLEN-1:0] rs1Data,
	input logic [XLEN-1:0] rs2Data,
	output rvCorePkg::execResT result,
	output logic redirect, // One cycle per taken branch or jump
	output logic [XLEN-1:0] redirectPc
);
	import rvCorePkg::*;

	logic inValid; // Entry not on a wrong path
	logic fwdA;
	logic fwdB;
	logic [XLEN-1:0] rs1Val;
	logic [XLEN-1:0] rs2Val;
	logic [XLEN-1:0] opA;
	logic [XLEN-1:0] opB;
	logic [4:0] shamt;
	logic [XLEN-1:0] aluOut;
	logic condMet;
	logic taken;
	logic [XLEN-1:0] targetSum;
	logic [XLEN-1:0] target;
	logic [XLEN-1:0] wbValue;
	execResT nextRes;

	// Previous redirect kills the entry behind it
	assign inValid = decoded.valid && !redirect;

	// Bypass from the last result, never for x0
	assign fwdA = result.valid && result.regWrite && (result.rd != '0)
		&& (result.rd == decoded.rs1);
	assign fwdB = result.valid && result.regWrite && (result.rd != '0)
		&& (result.rd == decoded.rs2);
	assign rs1Val = fwdA ? result.data : rs1Data;
	assign rs2Val = fwdB ? result.data : rs2Data;

	always_comb
	begin
		case (decoded.ctrl.opASel)
			SelRs1: opA = rs1Val;
			SelPc: opA = decoded.pc; // AUIPC
			default: opA = '0;
		endcase
	end

	assign opB = decoded.ctrl.useImm ? decoded.imm : rs2Val;
	assign shamt = opB[4:0]; // Low five bits only

	always_comb
	begin
		case (decoded.ctrl.aluOp)
			AluAdd: aluOut = opA + opB;
			AluSub: aluOut = opA - opB;
			AluSll: aluOut = opA << shamt;
			AluSlt: aluOut = {{(XLEN-1){1'b0}}, $signed(opA) < $signed(opB)};
			AluSltu: aluOut = {{(XLEN-1){1'b0}}, opA < opB};
			AluXor: aluOut = opA ^ opB;
			AluSrl: aluOut = opA >> shamt;
			AluSra: aluOut = XLEN'($signed(opA) >>> shamt); // Sign fill
			AluOr: aluOut = opA | opB;
			AluAnd: aluOut = opA & opB;
			AluPassB: aluOut = opB;
			default: aluOut = opA + opB;
		endcase
	end

	// Branch compare on forwarded register values
	always_comb
	begin
		case (decoded.ctrl.branchCond)
			3'b000: condMet = (rs1Val == rs2Val); // beq
			3'b001: condMet = (rs1Val != rs2Val); // bne
			3'b100: condMet = ($signed(rs1Val) < $signed(rs2Val)); // blt
			3'b101: condMet = ($signed(rs1Val) >= $signed(rs2Val)); // bge
			3'b110: condMet = (rs1Val < rs2Val); // bltu
			3'b111: condMet = (rs1Val >= rs2Val); // bgeu
			default: condMet = 1'b0;
		endcase
	end

	assign taken = inValid && (decoded.ctrl.isJal || decoded.ctrl.isJalr
		|| (decoded.ctrl.isBranch && condMet));

	// JALR is rs1-relative with bit 0 cleared
	assign targetSum = (decoded.ctrl.isJalr ? rs1Val : decoded.pc) + decoded.imm;
	assign target = {targetSum[XLEN-1:1], targetSum[0] & !decoded.ctrl.isJalr};

	assign wbValue = decoded.ctrl.linkPc ? (decoded.pc + XLEN'(4)) : aluOut;

	always_comb
	begin
		nextRes.valid = inValid;
		nextRes.rd = decoded.rd;
		nextRes.regWrite = inValid && decoded.ctrl.regWrite;
		nextRes.data = wbValue;
	end

	always_ff @(posedge clk or negedge nrst)
	begin
		if (!nrst)
		begin
			result <= '0;
			redirect <= 1'b0;
			redirectPc <= '0;
		end
		else
		begin
			result <= nextRes;
			redirect <= taken;
			redirectPc <= target;
		end
	end

endmodule

`default_nettype wire

// ==== regFile.sv ====
`default_nettype none

module regFile (
	input logic clk,
	input logic nrst,
	input logic [rvCorePkg::RegIdxW-1:0] rs1,
	input logic [rvCorePkg::RegIdxW-1:0] rs2,
	output logic [rvCorePkg::XLEN-1:0] rs1Data,
	output logic [rvCorePkg::XLEN-1:0] rs2Data,
	input logic wrEn,
	input logic [rvCorePkg::RegIdxW-1:0] wrAddr,
	input logic [rvCorePkg::XLEN-1:0] wrData
);
	import rvCorePkg::*;

	logic [XLEN-1:0] regs [1:31]; // No storage for x0

	// x0 reads zero, same-cycle write bypasses the array
	function automatic logic [XLEN-1:0] readPort(input logic [RegIdxW-1:0] addr);
		logic [XLEN-1:0] val;
		if (addr == '0)
			val = '0;
		else if (wrEn && (wrAddr == addr))
			val = wrData; // Write-through
		else
			val = regs[addr];
		return val;
	endfunction

	always_ff @(posedge clk or negedge nrst)
	begin
		if (!nrst)
		begin
			for (int i = 1; i < 32; i++)
				regs[i] <= '0;
		end
		else if (wrEn && (wrAddr != '0))
			regs[wrAddr] <= wrData;
	end

	always_comb
	begin
		rs1Data = readPort(rs1);
		rs2Data = readPort(rs2);
	end

endmodule

`default_nettype wire

// ==== instDecodeStage.sv ====
`default_nettype none

module instDecodeStage (
	input logic clk,
	input logic nrst,
	input logic [rvCorePkg::XLEN-1:0] pc,
	input logic [31:0] instr,
	input logic instrValid,
	input logic hold,
	input logic squash, // Redirect from execute
	output logic [rvCorePkg::RegIdxW-1:0] rs1,
	output logic [rvCorePkg::RegIdxW-1:0] rs2,
	output rvCorePkg::decodedT decoded
);
	import rvCorePkg::*;

	logic [XLEN-1:0] pcReg;
	logic [31:0] instrReg;
	logic validReg;

	opcodeT opcode;
	ctrlT ctrl;

	// Immediates by instruction format
	logic [XLEN-1:0] iImm;
	logic [XLEN-1:0] sImm;
	logic [XLEN-1:0] bImm;
	logic [XLEN-1:0] uImm;
	logic [XLEN-1:0] jImm;
	logic [XLEN-1:0] immSel;

	// Squash beats hold, hold beats capture
	always_ff @(posedge clk or negedge nrst)
	begin
		if (!nrst)
		begin
			pcReg <= '0;
			instrReg <= '0;
			validReg <= 1'b0;
		end
		else if (squash)
			validReg <= 1'b0; // Wrong-path input dropped
		else if (hold)
			validReg <= 1'b0; // pc and instr kept, bubble goes on
		else
		begin
			pcReg <= pc;
			instrReg <= instr;
			validReg <= instrValid;
		end
	end

	assign opcode = opcodeT'(instrReg[6:0]);
	assign rs1 = instrReg[19:15]; // Straight to regFile read ports
	assign rs2 = instrReg[24:20];

	assign iImm = {{(XLEN-12){instrReg[31]}}, instrReg[31:20]};
	assign sImm = {{(XLEN-12){instrReg[31]}}, instrReg[31:25], instrReg[11:7]};
	assign bImm = {{(XLEN-13){instrReg[31]}}, instrReg[31], instrReg[7],
		instrReg[30:25], instrReg[11:8], 1'b0};
	assign uImm = {instrReg[31:12], 12'b0}; // Upper 20 bits, low zero
	assign jImm = {{(XLEN-21){instrReg[31]}}, instrReg[31], instrReg[19:12],
		instrReg[20], instrReg[30:21], 1'b0};

	always_comb
	begin
		case (opcode)
			OpLui, OpAuipc: immSel = uImm;
			OpJal: immSel = jImm;
			OpBranch: immSel = bImm;
			OpJalr, OpImm: immSel = iImm;
			default: immSel = sImm; // Store format, opcode itself is a no-op
		endcase
	end

	ctrlDecoder ctrlDec (
		.instr (instrReg),
		.ctrl  (ctrl)
	);

	always_comb
	begin
		decoded.valid = validReg;
		decoded.pc = pcReg;
		decoded.rs1 = rs1;
		decoded.rs2 = rs2;
		decoded.rd = instrReg[11:7];
		decoded.imm = immSel;
		decoded.ctrl = ctrl;
	end

endmodule

`default_nettype wire

// ==== ctrlDecoder.sv ====
`default_nettype none

module ctrlDecoder (
	input logic [31:0] instr,
	output rvCorePkg::ctrlT ctrl
);
	import rvCorePkg::*;

	opcodeT opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;
	logic [RegIdxW-1:0] rd;
	logic writesRd; // Opcode produces a result

	// Shared funct3 map for OP and OP-IMM
	function automatic aluOpT aluFromFunct3(
		input logic [2:0] f3,
		input logic alt, // instr[30]
		input logic isReg
	);
		aluOpT op;
		case (f3)
			3'b000: op = (isReg && alt) ? AluSub : AluAdd; // No subi
			3'b001: op = AluSll;
			3'b010: op = AluSlt;
			3'b011: op = AluSltu;
			3'b100: op = AluXor;
			3'b101: op = alt ? AluSra : AluSrl; // Arithmetic by bit 30
			3'b110: op = AluOr;
			default: op = AluAnd;
		endcase
		return op;
	endfunction

	assign opcode = opcodeT'(instr[6:0]);
	assign funct3 = instr[14:12];
	assign funct7 = instr[31:25];
	assign rd = instr[11:7];

	always_comb
	begin
		ctrl = '0; // Default is a no-op
		ctrl.aluOp = AluAdd;
		ctrl.opASel = SelRs1;
		writesRd = 1'b0;
		case (opcode)
			OpLui:
			begin
				writesRd = 1'b1;
				ctrl.opASel = SelZero;
				ctrl.useImm = 1'b1;
				ctrl.aluOp = AluPassB; // U immediate as is
			end
			OpAuipc:
			begin
				writesRd = 1'b1;
				ctrl.opASel = SelPc; // pc + U immediate
				ctrl.useImm = 1'b1;
			end
			OpJal:
			begin
				writesRd = 1'b1;
				ctrl.isJal = 1'b1;
				ctrl.linkPc = 1'b1;
			end
			OpJalr:
			begin
				writesRd = 1'b1;
				ctrl.isJalr = 1'b1;
				ctrl.linkPc = 1'b1;
				ctrl.useImm = 1'b1;
			end
			OpBranch:
			begin
				ctrl.isBranch = (funct3[2:1] != 2'b01); // 010, 011 unassigned
				ctrl.branchCond = funct3;
			end
			OpImm:
			begin
				writesRd = 1'b1;
				ctrl.useImm = 1'b1;
				ctrl.aluOp = aluFromFunct3(funct3, instr[30], 1'b0);
			end
			OpReg:
			begin
				// Only base encodings, M extension falls out as no-op
				if ((funct7 == 7'b0000000) || (funct7 == 7'b0100000))
				begin
					writesRd = 1'b1;
					ctrl.aluOp = aluFromFunct3(funct3, instr[30], 1'b1);
				end
			end
			default:
			begin
				writesRd = 1'b0; // Loads, stores, system
			end
		endcase
		ctrl.regWrite = writesRd && (rd != '0); // x0 never written
	end

endmodule

`default_nettype wire

// ==== rvCorePkg.sv ====
`default_nettype none

package rvCorePkg;

	parameter int XLEN = 32; // Data path width
	parameter int RegIdxW = 5; // Register number width

	// RV32I major opcodes, instr[6:0]
	typedef enum logic [6:0]
	{
		OpLui    = 7'b0110111,
		OpAuipc  = 7'b0010111,
		OpJal    = 7'b1101111,
		OpJalr   = 7'b1100111,
		OpBranch = 7'b1100011,
		OpImm    = 7'b0010011,
		OpReg    = 7'b0110011
	} opcodeT;

	typedef enum logic [3:0]
	{
		AluAdd,
		AluSub,
		AluSll,
		AluSlt,
		AluSltu,
		AluXor,
		AluSrl,
		AluSra,
		AluOr,
		AluAnd,
		AluPassB // Operand B straight through
	} aluOpT;

	// Operand A source
	typedef enum logic [1:0]
	{
		SelRs1,
		SelPc,
		SelZero
	} opASelT;

	typedef struct packed
	{
		logic regWrite; // Never set for x0
		aluOpT aluOp;
		opASelT opASel;
		logic useImm; // Operand B from imm, else rs2
		logic isBranch;
		logic [2:0] branchCond; // Branch funct3
		logic isJal;
		logic isJalr;
		logic linkPc; // Write pc+4 instead of ALU
	} ctrlT;

	// Decode to execute
	typedef struct packed
	{
		logic valid;
		logic [XLEN-1:0] pc;
		logic [RegIdxW-1:0] rs1;
		logic [RegIdxW-1:0] rs2;
		logic [RegIdxW-1:0] rd;
		logic [XLEN-1:0] imm; // Selected immediate, sign-extended
		ctrlT ctrl;
	} decodedT;

	// Execute to result
	typedef struct packed
	{
		logic valid;
		logic [RegIdxW-1:0] rd;
		logic regWrite;
		logic [XLEN-1:0] data;
	} execResT;

endpackage

`default_nettype wire
